// File: common/periph_pkg.sv
// shared constants and types for the peripheral subsystem
// bus widths, register map, FIFO sizing, baud divider and serializer states
// modules pull these in with a wildcard import in their headers

`default_nettype none

package periph_pkg;

    //////////////////////////////////////////////////
    // bus
    //////////////////////////////////////////////////

    localparam int unsigned DAT_W  = 32;
    localparam int unsigned ADR_W  = 8;
    localparam int unsigned GPIO_W = 32;
    localparam int unsigned BYTE_W = 8;

    // address bit 6 picks the peripheral, 0 is GPIO and 1 is UART
    localparam int unsigned SEL_BIT = 6;

    // word offset field inside a peripheral, bits 5..2
    localparam int unsigned OFS_LSB = 2;
    localparam int unsigned OFS_W   = 4;

    //////////////////////////////////////////////////
    // register map (byte offsets)
    //////////////////////////////////////////////////

    localparam logic [ADR_W-1:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [ADR_W-1:0] GPIO_ENA_OFS = 8'h04;
    localparam logic [ADR_W-1:0] GPIO_INP_OFS = 8'h08;
    localparam logic [ADR_W-1:0] UART_DAT_OFS = 8'h00;
    localparam logic [ADR_W-1:0] UART_STS_OFS = 8'h04;

    // status register bits
    localparam int unsigned STS_FULL_BIT  = 0;
    localparam int unsigned STS_EMPTY_BIT = 1;
    localparam int unsigned STS_BUSY_BIT  = 2;

    //////////////////////////////////////////////////
    // UART
    //////////////////////////////////////////////////

    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

    // small divider keeps simulation short
    localparam int unsigned BAUD_DIV  = 4;
    localparam int unsigned BAUD_W    = $clog2(BAUD_DIV);
    localparam int unsigned BIT_CNT_W = $clog2(BYTE_W);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_state_t;

endpackage: periph_pkg

`default_nettype wire

// File: gpio/gpio_ctrl.sv
// GPIO controller with output and output-enable registers
// input pins pass a two-flop synchronizer before they can be read
// register reads are combinational on the offset from the bridge

`default_nettype none

module gpio_ctrl
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // register port
    input  logic              wen,
    input  logic [OFS_W-1:0]  ofs,
    input  logic [GPIO_W-1:0] wdt,
    output logic [GPIO_W-1:0] rdt,
    // pins
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    input  logic [GPIO_W-1:0] gpio_i
);

    logic [GPIO_W-1:0] sync_1;
    logic [GPIO_W-1:0] sync_2;

    // output and enable, both low out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (wen) begin
            if (ofs == GPIO_OUT_OFS[OFS_LSB +: OFS_W]) begin
                gpio_o <= wdt;
            end
            if (ofs == GPIO_ENA_OFS[OFS_LSB +: OFS_W]) begin
                gpio_e <= wdt;
            end
        end
    end

    // pin change shows up in sync_2 two edges later
    always_ff @(posedge clk) begin
        sync_1 <= gpio_i;
        sync_2 <= sync_1;
    end

    // read mux, zero for anything unmapped
    always_comb begin
        if (ofs == GPIO_OUT_OFS[OFS_LSB +: OFS_W]) begin
            rdt = gpio_o;
        end else if (ofs == GPIO_ENA_OFS[OFS_LSB +: OFS_W]) begin
            rdt = gpio_e;
        end else if (ofs == GPIO_INP_OFS[OFS_LSB +: OFS_W]) begin
            rdt = sync_2;
        end else begin
            rdt = '0;
        end
    end

endmodule: gpio_ctrl

`default_nettype wire

// File: logic/periph_bus.sv
// bus bridge between the request port and the GPIO and UART blocks
// registers each request, decodes the peripheral select bit and drives
// the GPIO write strobe or a FIFO push, then responds one cycle later

`default_nettype none

module periph_bus
    import periph_pkg::*;
(
    // system
    input  logic              clk,
    input  logic              rst,
    // request
    input  logic              req_vld,
    input  logic              req_wen,
    input  logic [ADR_W-1:0]  req_adr,
    input  logic [DAT_W-1:0]  req_wdt,
    // response
    output logic              rsp_vld,
    output logic [DAT_W-1:0]  rsp_rdt,
    // GPIO side
    output logic              gpio_wen,
    output logic [OFS_W-1:0]  gpio_ofs,
    output logic [GPIO_W-1:0] gpio_wdt,
    input  logic [GPIO_W-1:0] gpio_rdt,
    // UART FIFO side
    output logic              push,
    output logic [BYTE_W-1:0] push_dat,
    input  logic              full,
    input  logic              empty,
    input  logic              busy
);

    //////////////////////////////////////////////////
    // request register
    //////////////////////////////////////////////////

    logic             vld_q;
    logic             wen_q;
    logic             sel_q;
    logic [OFS_W-1:0] ofs_q;
    logic [DAT_W-1:0] wdt_q;

    // request valid stage
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= req_vld;
        end
    end

    // only the bits that the decoder looks at are kept
    always_ff @(posedge clk) begin
        if (req_vld) begin
            wen_q <= req_wen;
            sel_q <= req_adr[SEL_BIT];
            ofs_q <= req_adr[OFS_LSB +: OFS_W];
            wdt_q <= req_wdt;
        end
    end

    //////////////////////////////////////////////////
    // decode and write strobes
    //////////////////////////////////////////////////

    logic uart_dat_hit;
    logic uart_sts_hit;

    assign uart_dat_hit = sel_q && (ofs_q == UART_DAT_OFS[OFS_LSB +: OFS_W]);
    assign uart_sts_hit = sel_q && (ofs_q == UART_STS_OFS[OFS_LSB +: OFS_W]);

    // GPIO decodes its own offsets
    assign gpio_wen = vld_q && wen_q && !sel_q;
    assign gpio_ofs = ofs_q;
    assign gpio_wdt = wdt_q[GPIO_W-1:0];

    // data register write goes straight into the FIFO
    // a full FIFO drops the byte and status shows full
    assign push     = vld_q && wen_q && uart_dat_hit;
    assign push_dat = wdt_q[BYTE_W-1:0];

    //////////////////////////////////////////////////
    // read data and response
    //////////////////////////////////////////////////

    logic [DAT_W-1:0] rd_dat;

    always_comb begin
        rd_dat = '0;
        if (!wen_q) begin
            if (!sel_q) begin
                rd_dat = DAT_W'(gpio_rdt);
            end else if (uart_sts_hit) begin
                rd_dat[STS_FULL_BIT]  = full;
                rd_dat[STS_EMPTY_BIT] = empty;
                rd_dat[STS_BUSY_BIT]  = busy;
            end
            // UART data reads and unmapped offsets stay zero
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= vld_q;
        end
    end

    // writes also respond with zero data
    always_ff @(posedge clk) begin
        if (vld_q) begin
            rsp_rdt <= rd_dat;
        end
    end

    // every request gets exactly one response two edges later
    a_rsp_after_req: assert property (
        @(posedge clk) disable iff (rst)
        req_vld |-> ##2 rsp_vld
    );
    a_rsp_has_req: assert property (
        @(posedge clk) disable iff (rst)
        rsp_vld |-> $past(req_vld, 2)
    );

    // one request hits one peripheral only
    a_one_target: assert property (
        @(posedge clk) disable iff (rst)
        !(push && gpio_wen)
    );

endmodule: periph_bus

`default_nettype wire

// File: logic/periph_top.sv
// top level of the peripheral subsystem
// request port feeds the bus bridge, which serves the GPIO controller
// and the UART transmit path (FIFO and serializer)

`default_nettype none

module periph_top
    import periph_pkg::*;
(
    // system
    input  logic              clk,
    input  logic              rst,
    // request
    input  logic              req_vld,
    input  logic              req_wen,
    input  logic [ADR_W-1:0]  req_adr,
    input  logic [DAT_W-1:0]  req_wdt,
    // response
    output logic              rsp_vld,
    output logic [DAT_W-1:0]  rsp_rdt,
    // GPIO pins
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    input  logic [GPIO_W-1:0] gpio_i,
    // UART pin
    output logic              uart_txd
);

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    // bridge to GPIO
    logic              gpio_wen;
    logic [OFS_W-1:0]  gpio_ofs;
    logic [GPIO_W-1:0] gpio_wdt;
    logic [GPIO_W-1:0] gpio_rdt;

    // bridge to FIFO
    logic              push;
    logic [BYTE_W-1:0] push_dat;
    logic              full;
    logic              empty;

    // FIFO to serializer
    logic              pop;
    logic [BYTE_W-1:0] pop_dat;
    logic              busy;

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    periph_bus bus (
        .clk      (clk),
        .rst      (rst),
        .req_vld  (req_vld),
        .req_wen  (req_wen),
        .req_adr  (req_adr),
        .req_wdt  (req_wdt),
        .rsp_vld  (rsp_vld),
        .rsp_rdt  (rsp_rdt),
        .gpio_wen (gpio_wen),
        .gpio_ofs (gpio_ofs),
        .gpio_wdt (gpio_wdt),
        .gpio_rdt (gpio_rdt),
        .push     (push),
        .push_dat (push_dat),
        .full     (full),
        .empty    (empty),
        .busy     (busy)
    );

    gpio_ctrl gpio (
        .clk    (clk),
        .rst    (rst),
        .wen    (gpio_wen),
        .ofs    (gpio_ofs),
        .wdt    (gpio_wdt),
        .rdt    (gpio_rdt),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    uart_fifo fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_dat (push_dat),
        .pop      (pop),
        .pop_dat  (pop_dat),
        .full     (full),
        .empty    (empty)
    );

    uart_tx tx (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .pop_dat  (pop_dat),
        .pop      (pop),
        .busy     (busy),
        .uart_txd (uart_txd)
    );

endmodule: periph_top

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f vlog.f --top-module periph_tb -o sim_periph \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_periph)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1

// File: tb/periph_tb.sv
// testbench for the peripheral subsystem top level
// drives bus requests from an LFSR, models the GPIO registers and
// decodes the UART line against a queue of expected bytes

`default_nettype none

module periph_tb
    import periph_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////
    // constants
    //////////////////////////////////////////////////

    localparam logic [31:0]      SEED     = 32'h9ac0_b3d0;
    localparam logic [ADR_W-1:0] UART_BASE = ADR_W'(1) << SEL_BIT;
    localparam logic [ADR_W-1:0] UART_DAT_ADR = UART_BASE | UART_DAT_OFS;
    localparam logic [ADR_W-1:0] UART_STS_ADR = UART_BASE | UART_STS_OFS;
    localparam logic [DAT_W-1:0] STS_FULL  = DAT_W'(1) << STS_FULL_BIT;
    localparam logic [DAT_W-1:0] STS_IDLE  = DAT_W'(1) << STS_EMPTY_BIT;
    localparam logic [DAT_W-1:0] STS_BUSY  = DAT_W'(1) << STS_BUSY_BIT;

    // run length from reset, line frames, bus transfers and input holds
    localparam int N_BYTES     = 12 + 9;
    localparam int FRAME_CYC   = 10 * BAUD_DIV;
    localparam int N_XFERS     = 1 + 80 + 8 + 25 + 16 + 33;
    localparam int TEST_CYC    = 8 + N_BYTES * FRAME_CYC + N_XFERS * 3 + 8 * 4;
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;

    //////////////////////////////////////////////////
    // DUT and clock
    //////////////////////////////////////////////////

    logic              clk;
    logic              rst;
    logic              req_vld;
    logic              req_wen;
    logic [ADR_W-1:0]  req_adr;
    logic [DAT_W-1:0]  req_wdt;
    logic              rsp_vld;
    logic [DAT_W-1:0]  rsp_rdt;
    logic [GPIO_W-1:0] gpio_o;
    logic [GPIO_W-1:0] gpio_e;
    logic [GPIO_W-1:0] gpio_i;
    logic              uart_txd;

    periph_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .req_vld  (req_vld),
        .req_wen  (req_wen),
        .req_adr  (req_adr),
        .req_wdt  (req_wdt),
        .rsp_vld  (rsp_vld),
        .rsp_rdt  (rsp_rdt),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_txd)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // state, random source, checks
    //////////////////////////////////////////////////

    logic [31:0] lfsr;
    logic [31:0] model_out;
    logic [31:0] model_ena;
    logic [7:0]  exp_q [$];
    int          err_cnt;
    int          err_mark;
    int          n_checks;
    int          cyc_cnt;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        n_checks++;
        assert (got === exp) else begin
            err_cnt++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_pins();
        check_eq("gpio_o", model_out, gpio_o);
        check_eq("gpio_e", model_ena, gpio_e);
    endtask

    task automatic report_test(input int num, input string name);
        if (err_cnt == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    //////////////////////////////////////////////////
    // bus model
    //////////////////////////////////////////////////

    // one request with the response sampled one cycle after the request register
    task automatic bus_xfer(input logic wen, input logic [ADR_W-1:0] adr,
                            input logic [DAT_W-1:0] wdt, output logic [DAT_W-1:0] rdt);
        @(negedge clk);
        req_vld = 1'b1;
        req_wen = wen;
        req_adr = adr;
        req_wdt = wdt;
        @(negedge clk);
        req_vld = 1'b0;
        req_wen = 1'b0;
        req_adr = '0;
        req_wdt = '0;
        @(negedge clk);
        check_eq("rsp_vld", 32'h1, 32'(rsp_vld));
        rdt = rsp_rdt;
    endtask

    // writes answer with zero data
    task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] wdt);
        logic [DAT_W-1:0] rdt;
        bus_xfer(1'b1, adr, wdt, rdt);
        check_eq("rsp_rdt", 32'h0, rdt);
    endtask

    task automatic bus_read_check(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] exp);
        logic [DAT_W-1:0] rdt;
        bus_xfer(1'b0, adr, '0, rdt);
        check_eq("rsp_rdt", exp, rdt);
    endtask

    // poll status until FIFO empty and serializer idle
    task automatic wait_tx_idle();
        logic [DAT_W-1:0] sts;
        sts = '1;
        while (sts != STS_IDLE) begin
            bus_xfer(1'b0, UART_STS_ADR, '0, sts);
        end
    endtask

    // status must read idle one bit time after the last queued byte
    task automatic drain_line();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (BAUD_DIV) @(negedge clk);
        bus_read_check(UART_STS_ADR, STS_IDLE);
    endtask

    //////////////////////////////////////////////////
    // UART line monitor
    //////////////////////////////////////////////////

    initial begin : line_monitor
        logic [7:0] rx_byte;
        logic [7:0] exp_byte;
        wait (rst === 1'b0);
        forever begin
            @(negedge uart_txd);
            // mid start bit
            repeat (BAUD_DIV / 2) @(negedge clk);
            n_checks++;
            assert (uart_txd === 1'b0) else begin
                err_cnt++;
                $display("framing error: start bit went high before mid-bit");
            end
            if (uart_txd === 1'b0) begin
                // LSB first
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    rx_byte[i] = uart_txd;
                end
                repeat (BAUD_DIV) @(negedge clk);
                n_checks++;
                assert (uart_txd === 1'b1) else begin
                    err_cnt++;
                    $display("framing error: stop bit of byte %h is low", rx_byte);
                end
                n_checks++;
                assert (exp_q.size() > 0) else begin
                    err_cnt++;
                    $display("unexpected byte %h on the UART line, none was written", rx_byte);
                end
                if (exp_q.size() > 0) begin
                    exp_byte = exp_q.pop_front();
                    check_eq("uart_txd byte", 32'(exp_byte), 32'(rx_byte));
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic check_reset_state();
        check_eq("rsp_vld", 32'h0, 32'(rsp_vld));
        check_pins();
        check_eq("uart_txd", 32'h1, 32'(uart_txd));
        bus_read_check(UART_STS_ADR, STS_IDLE);
    endtask

    // random writes to out and enable with random low address bits
    task automatic exercise_gpio_regs();
        logic [31:0]      r;
        logic [31:0]      wdt;
        logic [ADR_W-1:0] adr;
        for (int i = 0; i < 40; i++) begin
            r   = rand_bits(3);
            adr = (r[0] ? GPIO_ENA_OFS : GPIO_OUT_OFS) | {6'b0, r[2:1]};
            wdt = rand_bits(32);
            bus_write(adr, wdt);
            if (r[0]) begin
                model_ena = wdt;
            end else begin
                model_out = wdt;
            end
            bus_read_check(adr, r[0] ? model_ena : model_out);
            check_pins();
        end
    endtask

    task automatic sample_gpio_inputs();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(32);
            @(negedge clk);
            gpio_i = r;
            repeat (4) @(negedge clk);
            bus_read_check(GPIO_INP_OFS, r);
        end
    endtask

    // one byte at a time with the line idle before each
    task automatic send_uart_bytes();
        logic [31:0] r;
        for (int i = 0; i < 12; i++) begin
            wait_tx_idle();
            r = rand_bits(32);
            exp_q.push_back(r[7:0]);
            bus_write(UART_DAT_ADR, r);
        end
        drain_line();
    endtask

    // 10 back-to-back writes and a status read in the next cycle
    task automatic overflow_fifo();
        logic [31:0] burst [10];
        wait_tx_idle();
        for (int i = 0; i < 10; i++) begin
            burst[i] = rand_bits(32);
            if (i < 9) begin
                exp_q.push_back(burst[i][7:0]);
            end
        end
        // request i answers at negedge i+2
        for (int i = 0; i <= 12; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_eq("rsp_vld", 32'h1, 32'(rsp_vld));
                check_eq("rsp_rdt", (i == 12) ? (STS_FULL | STS_BUSY) : 32'h0, rsp_rdt);
            end
            if (i < 10) begin
                req_vld = 1'b1;
                req_wen = 1'b1;
                req_adr = UART_DAT_ADR;
                req_wdt = burst[i];
            end else if (i == 10) begin
                req_vld = 1'b1;
                req_wen = 1'b0;
                req_adr = UART_STS_ADR;
                req_wdt = '0;
            end else begin
                req_vld = 1'b0;
                req_wen = 1'b0;
                req_adr = '0;
            end
        end
        drain_line();
    endtask

    // GPIO offsets 3..15, UART offsets 2..15 and the UART data register
    task automatic probe_unmapped();
        logic [31:0]      r;
        logic [3:0]       ofs;
        logic [ADR_W-1:0] adr;
        for (int i = 0; i < 8; i++) begin
            r   = rand_bits(4);
            ofs = (r[3:0] < 4'd3) ? r[3:0] + 4'd3 : r[3:0];
            adr = {2'b00, ofs, 2'b00};
            bus_read_check(adr, 32'h0);
            bus_write(adr, rand_bits(32));
            check_pins();
            r   = rand_bits(4);
            ofs = (r[3:0] < 4'd2) ? r[3:0] + 4'd2 : r[3:0];
            adr = UART_BASE | {2'b00, ofs, 2'b00};
            bus_read_check(adr, 32'h0);
            bus_write(adr, rand_bits(32));
            check_pins();
        end
        bus_read_check(UART_DAT_ADR, 32'h0);
    endtask

    //////////////////////////////////////////////////
    // sequence and timeout
    //////////////////////////////////////////////////

    initial begin : main
        clk       = 1'b0;
        rst       = 1'b1;
        req_vld   = 1'b0;
        req_wen   = 1'b0;
        req_adr   = '0;
        req_wdt   = '0;
        gpio_i    = '0;
        lfsr      = SEED;
        model_out = '0;
        model_ena = '0;
        err_cnt   = 0;
        err_mark  = 0;
        n_checks  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        report_test(1, "reset state");
        exercise_gpio_regs();
        report_test(2, "gpio registers");
        sample_gpio_inputs();
        report_test(3, "gpio input");
        send_uart_bytes();
        report_test(4, "uart bytes");
        overflow_fifo();
        report_test(5, "fifo overflow");
        probe_unmapped();
        report_test(6, "unmapped reads");

        $display("6 tests, %0d checks, %0d errors", n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        cyc_cnt = 0;
        while (cyc_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc_cnt++;
        end
        $display("timeout after %0d cycles, the run did not finish", cyc_cnt);
        $display("Testbench failed");
        $finish;
    end

endmodule: periph_tb

`default_nettype wire

// File: uart/uart_fifo.sv
// transmit byte FIFO between the bus bridge and the UART serializer
// circular buffer with read and write pointers and an occupancy count;
// push while full and pop while empty are ignored

`default_nettype none

module uart_fifo
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // write side
    input  logic              push,
    input  logic [BYTE_W-1:0] push_dat,
    // read side
    input  logic              pop,
    output logic [BYTE_W-1:0] pop_dat,
    // flags
    output logic              full,
    output logic              empty
);

    logic [BYTE_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   cnt;

    logic do_push;
    logic do_pop;

    // flags come straight off the count
    assign full  = (cnt == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (cnt == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    //////////////////////////////////////////////////
    // pointers and count
    //////////////////////////////////////////////////

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave count alone
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_dat;
        end
    end

    // head entry, valid whenever not empty
    assign pop_dat = mem[rd_ptr];

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (rst)
        cnt <= (FIFO_AW+1)'(FIFO_DEPTH)
    );

    // serializer must only pop a non-empty FIFO
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        !(pop && empty)
    );

endmodule: uart_fifo

`default_nettype wire

// File: uart/uart_tx.sv
// UART transmit serializer, 8N1 at a fixed divider from the package
// pops a byte from the FIFO when idle, then sends start, 8 data bits
// LSB first and a stop bit, each held for BAUD_DIV clock cycles

`default_nettype none

module uart_tx
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // FIFO side
    input  logic              empty,
    input  logic [BYTE_W-1:0] pop_dat,
    output logic              pop,
    // status and line
    output logic              busy,
    output logic              uart_txd
);

    uart_state_t          state;
    logic [BAUD_W-1:0]    baud_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BYTE_W-1:0]    shift;

    logic baud_end;
    logic last_bit;

    assign baud_end = (baud_cnt == BAUD_W'(BAUD_DIV-1));
    assign last_bit = (bit_cnt == BIT_CNT_W'(BYTE_W-1));

    // take the head byte as soon as one is there
    assign pop  = (state == TX_IDLE) && !empty;
    assign busy = (state != TX_IDLE);

    //////////////////////////////////////////////////
    // FSM, counters and line
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pop) begin
                        // start bit goes out on this edge
                        state    <= TX_START;
                        baud_cnt <= '0;
                        uart_txd <= 1'b0;
                    end
                end
                TX_START: begin
                    if (baud_end) begin
                        state    <= TX_DATA;
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        uart_txd <= shift[0];
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (baud_end) begin
                        baud_cnt <= '0;
                        if (last_bit) begin
                            state    <= TX_STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            uart_txd <= shift[0];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    // back to idle, next pop can follow in the next cycle
                    if (baud_end) begin
                        state    <= TX_IDLE;
                        baud_cnt <= '0;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state    <= TX_IDLE;
                    uart_txd <= 1'b1;
                end
            endcase
        end
    end

    // shifter, next bit always sits in bit 0
    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= pop_dat;
        end else if (baud_end && (state == TX_START || state == TX_DATA)) begin
            shift <= shift >> 1;
        end
    end

    // line idles high and the stop bit is high
    a_txd_high: assert property (
        @(posedge clk) disable iff (rst)
        (state == TX_IDLE || state == TX_STOP) |-> uart_txd
    );

endmodule: uart_tx

`default_nettype wire

// File: vlog.f
common/periph_pkg.sv
logic/periph_bus.sv
gpio/gpio_ctrl.sv
uart/uart_fifo.sv
uart/uart_tx.sv
logic/periph_top.sv
tb/periph_tb.sv
